//--- axi_pkg.sv
// shared AXI memory types
// widths, response codes, read owner and store word view

package axi_pkg;

    // bus field types
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  len_t;
    typedef logic [2:0]  size_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // responses the SRAM can give
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // who currently holds the shared read channel
    typedef enum logic [1:0] {
        OWNER_NONE,
        OWNER_IFU,
        OWNER_MEMU
    } read_owner_e;

    // one store word seen as bytes, halfwords or the whole word
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
        data_t            word;
    } store_word_u;

endpackage

//--- axi_rd_if.sv
// AXI read channel bundle

`timescale 1ns/1ps

interface axi_rd_if import axi_pkg::*; ();

    // read address channel
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    len_t  arlen;
    size_t arsize;

    // read data channel
    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;
    logic  rlast;

    modport master (
        output arvalid, araddr, arlen, arsize, rready,
        input  arready, rvalid, rdata, rresp, rlast
    );

    modport slave (
        input  arvalid, araddr, arlen, arsize, rready,
        output arready, rvalid, rdata, rresp, rlast
    );

endinterface

//--- axi_wr_if.sv
// AXI write channel bundle

`timescale 1ns/1ps

interface axi_wr_if import axi_pkg::*; ();

    // write address and data
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    len_t  awlen;
    size_t awsize;
    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;
    logic  wlast;

    // write response
    logic  bvalid;
    logic  bready;
    resp_t bresp;

    modport master (
        output awvalid, awaddr, awlen, awsize, wvalid, wdata, wstrb, wlast, bready,
        input  awready, wready, bvalid, bresp
    );

    modport slave (
        input  awvalid, awaddr, awlen, awsize, wvalid, wdata, wstrb, wlast, bready,
        output awready, wready, bvalid, bresp
    );

endinterface

//--- axi_arbiter.sv
// read arbiter and write path for the shared SRAM

`timescale 1ns/1ps

module axi_arbiter import axi_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    // fetch unit read side
    input  logic     ifu_arvalid,
    input  addr_t    ifu_araddr,
    input  len_t     ifu_arlen,
    input  size_t    ifu_arsize,
    input  logic     ifu_rready,
    output logic     ifu_arready,
    output logic     ifu_rvalid,
    output data_t    ifu_rdata,
    output resp_t    ifu_rresp,
    output logic     ifu_rlast,
    // load/store unit read side
    input  logic     mem_arvalid,
    input  addr_t    mem_araddr,
    input  len_t     mem_arlen,
    input  size_t    mem_arsize,
    input  logic     mem_rready,
    output logic     mem_arready,
    output logic     mem_rvalid,
    output data_t    mem_rdata,
    output resp_t    mem_rresp,
    output logic     mem_rlast,
    // load/store unit write side
    input  logic     mem_awvalid,
    input  addr_t    mem_awaddr,
    input  len_t     mem_awlen,
    input  size_t    mem_awsize,
    input  logic     mem_wvalid,
    input  data_t    mem_wdata,
    input  strb_t    mem_wstrb,
    input  logic     mem_wlast,
    input  logic     mem_bready,
    output logic     mem_awready,
    output logic     mem_wready,
    output logic     mem_bvalid,
    output resp_t    mem_bresp,
    axi_rd_if.master sram_rd,
    axi_wr_if.master sram_wr
);

    read_owner_e owner;
    logic        rd_done;
    logic        is_ifu;
    logic        is_memu;
    data_t       ifu_hold;
    data_t       mem_hold;
    logic        wr_busy;
    store_word_u store_in;
    store_word_u store_aligned;
    logic        strb_legal;

    assign is_ifu  = (owner == OWNER_IFU);
    assign is_memu = (owner == OWNER_MEMU);
    assign rd_done = sram_rd.rvalid && sram_rd.rready && sram_rd.rlast;

    // fixed priority, load/store side first
    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= OWNER_NONE;
        end else if (owner == OWNER_NONE) begin
            if (mem_arvalid) begin
                owner <= OWNER_MEMU;
            end else if (ifu_arvalid) begin
                owner <= OWNER_IFU;
            end
        end else if (rd_done) begin
            owner <= OWNER_NONE;
        end
    end

    // owner's request goes down to the SRAM
    assign sram_rd.arvalid = is_memu ? mem_arvalid : (is_ifu ? ifu_arvalid : 1'b0);
    assign sram_rd.araddr  = is_memu ? mem_araddr  : (is_ifu ? ifu_araddr  : '0);
    assign sram_rd.arlen   = is_memu ? mem_arlen   : (is_ifu ? ifu_arlen   : '0);
    assign sram_rd.arsize  = is_memu ? mem_arsize  : (is_ifu ? ifu_arsize  : '0);
    assign sram_rd.rready  = is_memu ? mem_rready  : (is_ifu ? ifu_rready  : 1'b0);

    // responses back to the owner only
    assign ifu_arready = is_ifu  ? sram_rd.arready : 1'b0;
    assign ifu_rvalid  = is_ifu  ? sram_rd.rvalid  : 1'b0;
    assign ifu_rresp   = is_ifu  ? sram_rd.rresp   : '0;
    assign ifu_rlast   = is_ifu  ? sram_rd.rlast   : 1'b0;
    assign mem_arready = is_memu ? sram_rd.arready : 1'b0;
    assign mem_rvalid  = is_memu ? sram_rd.rvalid  : 1'b0;
    assign mem_rresp   = is_memu ? sram_rd.rresp   : '0;
    assign mem_rlast   = is_memu ? sram_rd.rlast   : 1'b0;

    // last word each master took, kept after rvalid drops
    always_ff @(posedge clk) begin
        if (ifu_rvalid && ifu_rready) begin
            ifu_hold <= sram_rd.rdata;
        end
        if (mem_rvalid && mem_rready) begin
            mem_hold <= sram_rd.rdata;
        end
    end

    assign ifu_rdata = ifu_rvalid ? sram_rd.rdata : ifu_hold;
    assign mem_rdata = mem_rvalid ? sram_rd.rdata : mem_hold;

    // outstanding write, from address seen to response taken
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_busy <= 1'b0;
        end else if (!wr_busy && mem_awvalid) begin
            wr_busy <= 1'b1;
        end else if (sram_wr.bvalid && sram_wr.bready) begin
            wr_busy <= 1'b0;
        end
    end

    // move low byte or halfword onto the strobed lanes
    always_comb begin
        store_in.word      = mem_wdata;
        store_aligned.word = '0;
        strb_legal         = 1'b1;
        case (mem_wstrb)
            4'b0001: store_aligned.bytes[0]   = store_in.bytes[0];
            4'b0010: store_aligned.bytes[1]   = store_in.bytes[0];
            4'b0100: store_aligned.bytes[2]   = store_in.bytes[0];
            4'b1000: store_aligned.bytes[3]   = store_in.bytes[0];
            4'b0011: store_aligned.halves[0]  = store_in.halves[0];
            4'b0110: store_aligned.bytes[2:1] = store_in.halves[0];
            4'b1100: store_aligned.halves[1]  = store_in.halves[0];
            4'b1111: store_aligned.word       = store_in.word;
            default: strb_legal               = 1'b0;
        endcase
    end

    // write channels pass straight through
    assign sram_wr.awvalid = mem_awvalid;
    assign sram_wr.awaddr  = mem_awaddr;
    assign sram_wr.awlen   = mem_awlen;
    assign sram_wr.awsize  = mem_awsize;
    assign sram_wr.wvalid  = mem_wvalid;
    assign sram_wr.wdata   = store_aligned.word;
    assign sram_wr.wstrb   = mem_wstrb;
    assign sram_wr.wlast   = mem_wlast;
    assign sram_wr.bready  = mem_bready;
    assign mem_awready     = sram_wr.awready;
    assign mem_wready      = sram_wr.wready;
    assign mem_bvalid      = sram_wr.bvalid;
    assign mem_bresp       = sram_wr.bresp;

    // a burst in flight keeps its owner until rlast is taken
    a_owner_held: assert property (@(posedge clk) disable iff (reset)
        sram_rd.rvalid && !rd_done |=> $stable(owner));

    // single beat writes only
    a_awlen_zero: assert property (@(posedge clk) disable iff (reset)
        mem_awvalid && mem_awready |-> mem_awlen == '0);

    a_strb_legal: assert property (@(posedge clk) disable iff (reset)
        mem_wvalid |-> strb_legal);

    // a response only comes back for a tracked write
    a_b_tracked: assert property (@(posedge clk) disable iff (reset)
        sram_wr.bvalid |-> wr_busy);

endmodule

//--- axi_sram.sv
// on-chip SRAM with AXI read bursts and single-beat writes

`timescale 1ns/1ps

module axi_sram import axi_pkg::*; #(
    parameter int MEM_WORDS  = 1024,
    parameter int RD_LATENCY = 2
) (
    input  logic    clk,
    input  logic    reset,
    axi_rd_if.slave rd,
    axi_wr_if.slave wr
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int LW = (RD_LATENCY > 1) ? $clog2(RD_LATENCY) : 1;

    data_t mem [MEM_WORDS];

    // read burst state
    logic          rd_busy;
    logic [LW-1:0] lat_cnt;
    len_t          beats_left;
    logic [29:0]   rd_idx;
    logic          rd_in_range;
    logic          beat_load;
    logic          rvalid_q;
    logic          rlast_q;
    resp_t         rresp_q;
    data_t         rdata_q;

    // write state
    logic [29:0]   wr_idx;
    logic          wr_in_range;
    logic          wr_accept;
    logic          bvalid_q;
    resp_t         bresp_q;
    store_word_u   old_word;
    store_word_u   new_word;
    store_word_u   merged;

    assign rd_in_range = addr_t'(rd_idx) < addr_t'(MEM_WORDS);

    // next beat after latency, or right after an accepted non-last beat
    assign beat_load = rd_busy &&
                       ((!rvalid_q && lat_cnt == '0) || (rvalid_q && rd.rready && !rlast_q));

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy    <= 1'b0;
            rvalid_q   <= 1'b0;
            rlast_q    <= 1'b0;
            rresp_q    <= RESP_OKAY;
            lat_cnt    <= '0;
            beats_left <= '0;
            rd_idx     <= '0;
        end else if (!rd_busy) begin
            if (rd.arvalid) begin
                rd_busy    <= 1'b1;
                rd_idx     <= rd.araddr[31:2];
                beats_left <= rd.arlen;
                lat_cnt    <= LW'(RD_LATENCY - 1);
            end
        end else if (beat_load) begin
            rvalid_q   <= 1'b1;
            rlast_q    <= (beats_left == '0);
            rresp_q    <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
            rd_idx     <= rd_idx + 30'd1;
            beats_left <= beats_left - 8'd1;
        end else if (rvalid_q && rd.rready) begin
            // last beat taken
            rd_busy  <= 1'b0;
            rvalid_q <= 1'b0;
            rlast_q  <= 1'b0;
        end else if (!rvalid_q) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    // out of range beats read as zero
    always_ff @(posedge clk) begin
        if (beat_load) begin
            rdata_q <= rd_in_range ? mem[rd_idx[AW-1:0]] : '0;
        end
    end

    assign rd.arready = !rd_busy;
    assign rd.rvalid  = rvalid_q;
    assign rd.rlast   = rlast_q;
    assign rd.rresp   = rresp_q;
    assign rd.rdata   = rdata_q;

    // address and data taken together, one response at a time
    assign wr_idx      = wr.awaddr[31:2];
    assign wr_in_range = addr_t'(wr_idx) < addr_t'(MEM_WORDS);
    assign wr_accept   = wr.awvalid && wr.wvalid && !bvalid_q;

    always_comb begin
        old_word.word = mem[wr_idx[AW-1:0]];
        new_word.word = wr.wdata;
        merged        = old_word;
        for (int i = 0; i < 4; i++) begin
            if (wr.wstrb[i]) begin
                merged.bytes[i] = new_word.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept && wr_in_range) begin
            mem[wr_idx[AW-1:0]] <= merged.word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            bresp_q  <= RESP_OKAY;
        end else if (wr_accept) begin
            bvalid_q <= 1'b1;
            bresp_q  <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end else if (wr.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    assign wr.awready = wr_accept;
    assign wr.wready  = wr_accept;
    assign wr.bvalid  = bvalid_q;
    assign wr.bresp   = bresp_q;

    // a stalled beat keeps its data
    a_rdata_hold: assert property (@(posedge clk) disable iff (reset)
        rd.rvalid && !rd.rready |=> rd.rvalid && $stable(rd.rdata));

endmodule

//--- mem_subsys_top.sv
// memory subsystem top

`timescale 1ns/1ps

module mem_subsys_top import axi_pkg::*; #(
    parameter int MEM_WORDS  = 1024,
    parameter int RD_LATENCY = 2
) (
    input  logic  clk,
    input  logic  reset,
    // fetch unit
    input  logic  ifu_arvalid,
    input  addr_t ifu_araddr,
    input  len_t  ifu_arlen,
    input  size_t ifu_arsize,
    input  logic  ifu_rready,
    output logic  ifu_arready,
    output logic  ifu_rvalid,
    output data_t ifu_rdata,
    output resp_t ifu_rresp,
    output logic  ifu_rlast,
    // load/store unit reads
    input  logic  mem_arvalid,
    input  addr_t mem_araddr,
    input  len_t  mem_arlen,
    input  size_t mem_arsize,
    input  logic  mem_rready,
    output logic  mem_arready,
    output logic  mem_rvalid,
    output data_t mem_rdata,
    output resp_t mem_rresp,
    output logic  mem_rlast,
    // load/store unit writes
    input  logic  mem_awvalid,
    input  addr_t mem_awaddr,
    input  len_t  mem_awlen,
    input  size_t mem_awsize,
    input  logic  mem_wvalid,
    input  data_t mem_wdata,
    input  strb_t mem_wstrb,
    input  logic  mem_wlast,
    input  logic  mem_bready,
    output logic  mem_awready,
    output logic  mem_wready,
    output logic  mem_bvalid,
    output resp_t mem_bresp
);

    axi_rd_if rd_sram ();
    axi_wr_if wr_sram ();

    axi_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .ifu_arvalid(ifu_arvalid), .ifu_araddr(ifu_araddr), .ifu_arlen(ifu_arlen),
        .ifu_arsize(ifu_arsize), .ifu_rready(ifu_rready), .ifu_arready(ifu_arready),
        .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata), .ifu_rresp(ifu_rresp),
        .ifu_rlast(ifu_rlast),
        .mem_arvalid(mem_arvalid), .mem_araddr(mem_araddr), .mem_arlen(mem_arlen),
        .mem_arsize(mem_arsize), .mem_rready(mem_rready), .mem_arready(mem_arready),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata), .mem_rresp(mem_rresp),
        .mem_rlast(mem_rlast),
        .mem_awvalid(mem_awvalid), .mem_awaddr(mem_awaddr), .mem_awlen(mem_awlen),
        .mem_awsize(mem_awsize), .mem_wvalid(mem_wvalid), .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb), .mem_wlast(mem_wlast), .mem_bready(mem_bready),
        .mem_awready(mem_awready), .mem_wready(mem_wready), .mem_bvalid(mem_bvalid),
        .mem_bresp(mem_bresp),
        .sram_rd(rd_sram), .sram_wr(wr_sram)
    );

    axi_sram #(
        .MEM_WORDS (MEM_WORDS),
        .RD_LATENCY(RD_LATENCY)
    ) u_sram (
        .clk  (clk),
        .reset(reset),
        .rd   (rd_sram),
        .wr   (wr_sram)
    );

endmodule

//--- tb_mem_subsys.sv
// memory subsystem testbench

`timescale 1ns/1ps

module tb_mem_subsys import axi_pkg::*; ();

    localparam int MEM_WORDS  = 256;
    localparam int RD_LATENCY = 2;
    localparam int N_BURST    = 24;
    localparam int MAX_BEATS  = 16;
    localparam int STALL      = 8;
    // fill writes, then every burst beat at worst stall, plus margin
    localparam int LIMIT = MEM_WORDS * 8 + (N_BURST * MAX_BEATS + 200) * STALL + 2000;
    localparam strb_t LEGAL_STRB [8] = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hc, 4'hf};

    logic  clk;
    logic  reset;
    logic  ifu_arvalid, ifu_rready, ifu_arready, ifu_rvalid, ifu_rlast;
    logic  mem_arvalid, mem_rready, mem_arready, mem_rvalid, mem_rlast;
    logic  mem_awvalid, mem_wvalid, mem_wlast, mem_bready;
    logic  mem_awready, mem_wready, mem_bvalid;
    addr_t ifu_araddr, mem_araddr, mem_awaddr;
    len_t  ifu_arlen, mem_arlen, mem_awlen;
    size_t ifu_arsize, mem_arsize, mem_awsize;
    data_t ifu_rdata, mem_rdata, mem_wdata;
    resp_t ifu_rresp, mem_rresp, mem_bresp;
    strb_t mem_wstrb;

    // reference memory and expected beats as {last, resp, data}
    data_t       ref_mem [MEM_WORDS];
    logic [34:0] ifu_exp [$];
    logic [34:0] mem_exp [$];
    logic [15:0] lfsr;
    int          cyc = 0;
    int          ifu_done = 0;
    int          mem_done = 0;
    int          ifu_rise_cyc = 0;
    int          mem_end_cyc = 0;
    int          err_data = 0;
    int          err_resp = 0;
    int          err_flag = 0;
    int          err_other = 0;
    logic [34:0] ifu_beat, mem_beat;
    data_t       ifu_last, mem_last;
    logic        ifu_seen = 1'b0;
    logic        mem_seen = 1'b0;
    logic        ifu_prev_valid = 1'b0;

    mem_subsys_top #(
        .MEM_WORDS (MEM_WORDS),
        .RD_LATENCY(RD_LATENCY)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // low byte or halfword shifted up to the lowest strobed lane
    function automatic data_t ref_merge(input data_t old, input data_t wd, input strb_t s);
        data_t lanes;
        data_t res;
        int    low;
        low = 0;
        while (!s[low] && low < 3) low++;
        lanes = wd << (8 * low);
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) res[8*i +: 8] = lanes[8*i +: 8];
        end
        return res;
    endfunction

    function automatic void expect_read(input addr_t addr, output data_t d, output resp_t r);
        if (addr[31:2] >= MEM_WORDS) begin
            d = '0;
            r = RESP_SLVERR;
        end else begin
            d = ref_mem[int'(addr[31:2])];
            r = RESP_OKAY;
        end
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            err_data++;
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            err_resp++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            err_flag++;
        end
    endtask

    task automatic check_beat(input string name, input logic [34:0] exp, input data_t d,
                              input resp_t r, input logic l);
        check_data(name, exp[31:0], d);
        check_resp({name, " rresp"}, exp[33:32], r);
        check_flag({name, " rlast"}, exp[34], l);
    endtask

    task automatic write_word(input addr_t addr, input data_t wd, input strb_t s,
                              input bit stall);
        resp_t exp_r;
        exp_r = (addr[31:2] >= MEM_WORDS) ? RESP_SLVERR : RESP_OKAY;
        @(posedge clk);
        mem_awvalid <= 1'b1;
        mem_wvalid  <= 1'b1;
        mem_awaddr  <= addr;
        mem_wdata   <= wd;
        mem_wstrb   <= s;
        do @(posedge clk); while (!mem_awready);
        // address and data are taken in the same edge
        check_flag("write wready", 1'b1, mem_wready);
        mem_awvalid <= 1'b0;
        mem_wvalid  <= 1'b0;
        mem_bready  <= stall ? (rand_bits(1) != 0) : 1'b1;
        forever begin
            @(posedge clk);
            if (mem_bvalid && mem_bready) break;
            mem_bready <= stall ? (rand_bits(1) != 0) : 1'b1;
        end
        mem_bready <= 1'b0;
        check_resp("write bresp", exp_r, mem_bresp);
        if (exp_r == RESP_OKAY) begin
            ref_mem[int'(addr[31:2])] = ref_merge(ref_mem[int'(addr[31:2])], wd, s);
        end
    endtask

    // queue the expected beats, issue the address, wait for the rlast beat
    task automatic read_burst(input bit use_ifu, input addr_t addr, input len_t len,
                              input bit stall);
        data_t d;
        resp_t r;
        int    target;
        for (int i = 0; i <= int'(len); i++) begin
            expect_read(addr + addr_t'(4 * i), d, r);
            if (use_ifu) ifu_exp.push_back({i == int'(len), r, d});
            else mem_exp.push_back({i == int'(len), r, d});
        end
        target = (use_ifu ? ifu_done : mem_done) + 1;
        @(posedge clk);
        if (use_ifu) begin
            ifu_arvalid <= 1'b1;
            ifu_araddr  <= addr;
            ifu_arlen   <= len;
        end else begin
            mem_arvalid <= 1'b1;
            mem_araddr  <= addr;
            mem_arlen   <= len;
        end
        while ((use_ifu ? ifu_done : mem_done) != target) begin
            @(posedge clk);
            if (use_ifu) begin
                if (ifu_arvalid && ifu_arready) ifu_arvalid <= 1'b0;
                ifu_rready <= stall ? (rand_bits(2) != 0) : 1'b1;
            end else begin
                if (mem_arvalid && mem_arready) mem_arvalid <= 1'b0;
                mem_rready <= stall ? (rand_bits(2) != 0) : 1'b1;
            end
        end
        if ((use_ifu ? ifu_exp.size() : mem_exp.size()) != 0) begin
            $display("Read burst at %h ended before all %0d beats arrived", addr, len + 1);
            err_other++;
            if (use_ifu) ifu_exp.delete();
            else mem_exp.delete();
        end
    endtask

    task automatic print_counts();
        $display("Errors: data %0d, resp %0d, flag %0d, other %0d",
                 err_data, err_resp, err_flag, err_other);
    endtask

    // fetch port beats, and the held word once rvalid is low
    always @(posedge clk) begin
        if (ifu_rvalid && !ifu_prev_valid) ifu_rise_cyc = cyc;
        ifu_prev_valid = ifu_rvalid;
        if (ifu_rvalid && ifu_rready) begin
            if (ifu_exp.size() == 0) begin
                $display("Fetch port returned a read beat that was never requested");
                err_other++;
            end else begin
                ifu_beat = ifu_exp.pop_front();
                check_beat("ifu read", ifu_beat, ifu_rdata, ifu_rresp, ifu_rlast);
                ifu_last = ifu_beat[31:0];
                ifu_seen = 1'b1;
            end
            if (ifu_rlast) ifu_done <= ifu_done + 1;
        end else if (ifu_seen && !ifu_rvalid) begin
            check_data("ifu rdata hold", ifu_last, ifu_rdata);
        end
    end

    // load/store port beats
    always @(posedge clk) begin
        if (mem_rvalid && mem_rready) begin
            if (mem_exp.size() == 0) begin
                $display("Load/store port returned a read beat that was never requested");
                err_other++;
            end else begin
                mem_beat = mem_exp.pop_front();
                check_beat("memu read", mem_beat, mem_rdata, mem_rresp, mem_rlast);
                mem_last = mem_beat[31:0];
                mem_seen = 1'b1;
            end
            if (mem_rlast) begin
                mem_done <= mem_done + 1;
                mem_end_cyc = cyc;
            end
        end else if (mem_seen && !mem_rvalid) begin
            check_data("memu rdata hold", mem_last, mem_rdata);
        end
    end

    initial begin
        while (cyc < LIMIT) begin
            @(posedge clk);
            cyc <= cyc + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        print_counts();
        $display("Test failed");
        $finish;
    end

    initial begin
        addr_t a;
        addr_t b;
        len_t  len;
        int    k;
        lfsr = 16'd18308;
        reset       <= 1'b1;
        ifu_arvalid <= 1'b0;
        ifu_araddr  <= '0;
        ifu_arlen   <= '0;
        ifu_arsize  <= 3'd2;
        ifu_rready  <= 1'b0;
        mem_arvalid <= 1'b0;
        mem_araddr  <= '0;
        mem_arlen   <= '0;
        mem_arsize  <= 3'd2;
        mem_rready  <= 1'b0;
        mem_awvalid <= 1'b0;
        mem_awaddr  <= '0;
        mem_awlen   <= '0;
        mem_awsize  <= 3'd2;
        mem_wvalid  <= 1'b0;
        mem_wdata   <= '0;
        mem_wstrb   <= 4'hf;
        mem_wlast   <= 1'b1;
        mem_bready  <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // preload every word, SRAM contents are not reset
        for (int w = 0; w < MEM_WORDS; w++) begin
            write_word(addr_t'(w) << 2, (addr_t'(w) * 32'h9e37_79b1) ^ rand_bits(32),
                       4'hf, 1'b0);
        end

        repeat (8) read_burst(1'b1, addr_t'(rand_bits(8) << 2), 8'd0, 1'b0);

        // may run past the end, those beats expect SLVERR
        repeat (N_BURST) begin
            a = addr_t'(rand_bits(8) << 2);
            len = len_t'(rand_bits(4));
            read_burst(1'b0, a, len, 1'b1);
        end

        // both masters in the same cycle, load/store side wins
        repeat (4) begin
            a = addr_t'(rand_bits(8) << 2);
            b = addr_t'(rand_bits(8) << 2);
            len = len_t'(rand_bits(3));
            fork
                read_burst(1'b0, a, len, 1'b0);
                read_burst(1'b1, b, 8'd0, 1'b0);
            join
            if (ifu_rise_cyc <= mem_end_cyc) begin
                $display("Fetch data came back before the load/store burst had ended");
                err_other++;
            end
        end

        repeat (2) begin
            foreach (LEGAL_STRB[i]) begin
                a = addr_t'(rand_bits(8) << 2);
                write_word(a, rand_bits(32), LEGAL_STRB[i], 1'b1);
                read_burst(1'b0, a, 8'd0, 1'b1);
            end
        end

        // past the end, then the aliased in-range word must be untouched
        repeat (4) begin
            k = int'(rand_bits(8));
            write_word(addr_t'(MEM_WORDS + k) << 2, rand_bits(32), 4'hf, 1'b1);
            read_burst(1'b0, addr_t'(MEM_WORDS + k) << 2, 8'd3, 1'b0);
            read_burst(1'b1, addr_t'(k) << 2, 8'd0, 1'b0);
        end

        repeat (4) @(posedge clk);
        print_counts();
        if (err_data + err_resp + err_flag + err_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
axi_pkg.sv
axi_rd_if.sv
axi_wr_if.sv
axi_arbiter.sv
axi_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- Makefile
TOOL    := verilator
TOP     := tb_mem_subsys
FLIST   := build.f
FLAGS   := --binary --timing --assert -Wno-fatal
LINT    := --lint-only --timing -Wall
BUILD   := obj_dir
LOG     := sim.log
PASS    := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
